// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the UART debug bridge simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_uart_dbg \
  -f sim.f -Mdir obj_dir -o tb_uart_dbg > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed"
  exit 1
fi

./obj_dir/tb_uart_dbg > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "sim failed" sim.log; then
  exit 1
fi
exit 0

// File: sim.f
+incdir+verilog
verilog/dbg_proto_pkg.sv
verilog/dbg_bus_pkg.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/dbg_cmd_engine.sv
verilog/uart_dbg_top.sv
tests/tb_clock_gen.sv
tests/uart_dbg_asserts.sv
tests/tb_uart_dbg.sv

// File: tests/tb_clock_gen.sv
// Testbench clock source with a synchronous reset held for the first four cycles
module tb_clock_gen (
  output logic clk,
  output logic reset_o
);

  // Period of 40 time units
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    reset_o = 1'b1;
    repeat (4) @(posedge clk);
    reset_o <= 1'b0;
  end

endmodule

// File: tests/tb_uart_dbg.sv
// Testbench for the UART debug bridge with host UART, Wishbone memory model and stimulus table
`include "uart_dbg_consts.svh"

module tb_uart_dbg import dbg_proto_pkg::*, dbg_bus_pkg::*; ();

  localparam int K_CHAL  = 0;
  localparam int K_WRITE = 1;
  localparam int K_READ  = 2;
  localparam int K_JUNK  = 3;

  logic       clk;
  logic       reset_i;
  logic       uart_rx_i;
  logic       uart_tx_o;
  logic       wb_cyc_o;
  logic       wb_stb_o;
  logic       wb_we_o;
  wb_adr_t    wb_adr_o;
  wb_dat_t    wb_dat_o;
  wb_dat_t    wb_dat_i = '0;
  logic       wb_ack_i = 1'b0;

  logic [7:0]  mem [0:65535];
  logic [7:0]  exp_mem [0:65535];
  logic [1:0]  wait_cnt;
  logic [32:0] bus_log [$];
  logic [7:0]  rx_q [$];
  int          starts;
  int          errors;
  int          tests_run;
  int          tests_failed;
  int          limit;

  // Stimulus table
  string       t_name [$];
  int          t_kind [$];
  wb_adr_t     t_addr [$];
  dbg_len_t    t_len  [$];
  logic [63:0] t_data [$];

  tb_clock_gen u_clk (
    .clk     ( clk     ),
    .reset_o ( reset_i )
  );

  uart_dbg_top dut0 (
    .clk       ( clk       ),
    .reset_i   ( reset_i   ),
    .uart_rx_i ( uart_rx_i ),
    .uart_tx_o ( uart_tx_o ),
    .wb_cyc_o  ( wb_cyc_o  ),
    .wb_stb_o  ( wb_stb_o  ),
    .wb_we_o   ( wb_we_o   ),
    .wb_adr_o  ( wb_adr_o  ),
    .wb_dat_o  ( wb_dat_o  ),
    .wb_dat_i  ( wb_dat_i  ),
    .wb_ack_i  ( wb_ack_i  )
  );

  function automatic logic [7:0] fill_byte(input logic [15:0] a);
    return a[7:0] ^ {a[11:8], a[15:12]} ^ 8'h3c;
  endfunction

  ////////////////////
  // Wishbone slave
  ////////////////////

  // Ack after 0 to 3 wait cycles
  always @(posedge clk) begin
    if (reset_i) begin
      wb_ack_i <= 1'b0;
      wait_cnt <= 2'($urandom_range(3, 0));
      for (int a = 0; a < 65536; a++) begin
        mem[a] <= fill_byte(16'(a));
      end
    end else begin
      wb_ack_i <= 1'b0;
      if (wb_cyc_o && wb_stb_o && !wb_ack_i) begin
        if (wait_cnt != 2'd0) begin
          wait_cnt <= wait_cnt - 2'd1;
        end else begin
          wb_ack_i <= 1'b1;
          wait_cnt <= 2'($urandom_range(3, 0));
          bus_log.push_back({wb_we_o, wb_adr_o});
          if (wb_we_o) begin
            mem[wb_adr_o[15:0]] <= wb_dat_o;
          end else begin
            wb_dat_i <= mem[wb_adr_o[15:0]];
          end
        end
      end
    end
  end

  ////////////////////
  // Host UART
  ////////////////////

  task automatic send_byte(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      uart_rx_i <= frame[i];
      repeat (`DBG_CLKS_PER_BIT - 1) @(posedge clk);
    end
  endtask

  // Eight bytes with the lowest first
  task automatic send_field(input logic [63:0] v);
    for (int i = 0; i < `DBG_HDR_BYTES; i++) begin
      send_byte(v[8*i +: 8]);
    end
  endtask

  // Reply line sampled at mid-bit on the falling clock edge
  initial begin : reply_monitor
    logic [7:0] b;
    forever begin
      @(negedge clk);
      if (reset_i === 1'b0 && uart_tx_o === 1'b0) begin
        starts++;
        repeat (`DBG_CLKS_PER_BIT / 2) @(negedge clk);
        for (int i = 0; i < 8; i++) begin
          repeat (`DBG_CLKS_PER_BIT) @(negedge clk);
          b[i] = uart_tx_o;
        end
        repeat (`DBG_CLKS_PER_BIT) @(negedge clk);
        if (uart_tx_o !== 1'b1) begin
          $display("reply frame ended with a low stop bit");
          errors++;
        end
        rx_q.push_back(b);
      end
    end
  end

  ////////////////////
  // Checks and tests
  ////////////////////

  task automatic compare_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
    if (expected !== actual) begin
      $display("mismatch %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("test %s ok", name);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d errors", name, errors - err_before);
    end
  endtask

  task automatic add_test(input string name, input int kind, input wb_adr_t addr,
                          input dbg_len_t len, input logic [63:0] data);
    t_name.push_back(name);
    t_kind.push_back(kind);
    t_addr.push_back(addr);
    t_len.push_back(len);
    t_data.push_back(data);
  endtask

  // Bytes sent plus bytes expected over all tests
  function automatic int calc_limit();
    int bytes;
    bytes = 0;
    foreach (t_kind[t]) begin
      case (t_kind[t])
        K_CHAL:  bytes += 2;
        K_JUNK:  bytes += 1;
        default: bytes += 1 + 2 * `DBG_HDR_BYTES + 2 + int'(t_len[t]);
      endcase
    end
    return 2 * bytes * 10 * `DBG_CLKS_PER_BIT + 1000;
  endfunction

  task automatic run_test(input int t);
    logic [7:0]  exp_q [$];
    logic [15:0] a;
    int          n_bus;
    int          log_base;
    int          err_before;
    err_before = errors;
    n_bus = 0;
    log_base = bus_log.size();
    rx_q.delete();
    starts = 0;
    if (t_kind[t] == K_CHAL) begin
      send_byte(`DBG_BYTE_ACK);
      exp_q.push_back(`DBG_BYTE_ACK);
    end else if (t_kind[t] == K_JUNK) begin
      send_byte(t_data[t][7:0]);
    end else begin
      send_byte(t_kind[t] == K_WRITE ? DBG_OP_WRITE : DBG_OP_READ);
      send_field(64'(t_addr[t]));
      send_field(64'(t_len[t]));
      exp_q.push_back(`DBG_BYTE_ACK);
      n_bus = int'(t_len[t]);
      for (int i = 0; i < n_bus; i++) begin
        a = 16'(t_addr[t]) + 16'(i);
        if (t_kind[t] == K_WRITE) begin
          send_byte(t_data[t][8*i +: 8]);
        end else begin
          exp_q.push_back(exp_mem[a]);
        end
      end
      exp_q.push_back(`DBG_BYTE_EOT);
    end
    while (rx_q.size() < exp_q.size()) begin
      @(negedge clk);
    end
    // Quiet gap catches stray replies
    repeat (20 * `DBG_CLKS_PER_BIT) @(negedge clk);
    compare_value({t_name[t], " reply count"}, 64'(exp_q.size()), 64'(starts));
    foreach (exp_q[i]) begin
      compare_value({t_name[t], " reply byte"}, 64'(exp_q[i]), 64'(rx_q[i]));
    end
    compare_value({t_name[t], " bus cycles"}, 64'(n_bus), 64'(bus_log.size() - log_base));
    for (int i = log_base; i < bus_log.size(); i++) begin
      compare_value({t_name[t], " bus access"},
                    {31'd0, t_kind[t] == K_WRITE, t_addr[t] + 32'(i - log_base)},
                    64'(bus_log[i]));
    end
    if (t_kind[t] == K_WRITE) begin
      for (int i = 0; i < n_bus; i++) begin
        a = 16'(t_addr[t]) + 16'(i);
        compare_value({t_name[t], " memory"}, 64'(t_data[t][8*i +: 8]), 64'(mem[a]));
        exp_mem[a] = t_data[t][8*i +: 8];
      end
    end
    report_test(t_name[t], err_before);
  endtask

  initial begin : watchdog
    int cycles;
    cycles = 0;
    wait (limit > 0);
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: tests did not finish within %0d clock cycles", limit);
    $display("sim failed");
    $finish;
  end

  initial begin : main
    int err_before;
    void'($urandom(32'heb202f4c));
    uart_rx_i = 1'b1;
    add_test("challenge", K_CHAL, '0, '0, '0);
    add_test("write_4", K_WRITE, 32'h0000_0100, 16'd4, 64'h0000_0000_c3b2_a1f0);
    add_test("read_4", K_READ, 32'h0000_0100, 16'd4, '0);
    add_test("write_8_top", K_WRITE, 32'h0000_fff8, 16'd8, 64'h0123_4567_89ab_cdef);
    add_test("read_8_top", K_READ, 32'h0000_fff8, 16'd8, '0);
    add_test("read_span", K_READ, 32'h0000_00fe, 16'd7, '0);
    add_test("read_zero", K_READ, 32'h0000_0200, 16'd0, '0);
    add_test("write_zero", K_WRITE, 32'h0000_0300, 16'd0, '0);
    add_test("junk", K_JUNK, '0, '0, 64'h55);
    add_test("challenge_after_junk", K_CHAL, '0, '0, '0);
    for (int a = 0; a < 65536; a++) begin
      exp_mem[a] = fill_byte(16'(a));
    end
    limit = calc_limit();
    @(negedge reset_i);
    // Line idle and bus quiet before any stimulus
    err_before = errors;
    repeat (40) begin
      @(negedge clk);
      compare_value("idle_after_reset tx line", 64'd1, 64'(uart_tx_o));
      compare_value("idle_after_reset cyc", 64'd0, 64'(wb_cyc_o));
      compare_value("idle_after_reset stb", 64'd0, 64'(wb_stb_o));
    end
    report_test("idle_after_reset", err_before);
    foreach (t_kind[t]) begin
      run_test(t);
    end
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: tests/uart_dbg_asserts.sv
// Bound checks on the command engine Wishbone master and reply byte handshake
module uart_dbg_asserts import dbg_bus_pkg::*; (
  input logic    clk,
  input logic    reset_i,
  input logic    cyc_i,
  input logic    stb_i,
  input logic    we_i,
  input logic    ack_i,
  input wb_adr_t adr_i,
  input wb_dat_t dat_i,
  input logic    tx_valid_i,
  input logic    tx_ready_i,
  input wb_dat_t tx_byte_i
);

  // Cycle and strobe both drop the clock after the ack
  cyc_release: assert property (@(posedge clk) disable iff (reset_i)
      (cyc_i && stb_i && ack_i) |=> !(cyc_i || stb_i))
    else $error("wishbone cycle still open after ack");

  // Request held until the slave acks
  req_stable: assert property (@(posedge clk) disable iff (reset_i)
      (stb_i && !ack_i) |=> ($stable(adr_i) && $stable(we_i) && (!we_i || $stable(dat_i))))
    else $error("wishbone request changed before ack");

  // Reply byte held while the transmitter is busy
  tx_stable: assert property (@(posedge clk) disable iff (reset_i)
      (tx_valid_i && !tx_ready_i) |=> $stable(tx_byte_i))
    else $error("reply byte changed while waiting for the transmitter");

endmodule

bind dbg_cmd_engine uart_dbg_asserts u_asserts (
  .clk        ( clk        ),
  .reset_i    ( reset_i    ),
  .cyc_i      ( wb_cyc_o   ),
  .stb_i      ( wb_stb_o   ),
  .we_i       ( wb_we_o    ),
  .ack_i      ( wb_ack_i   ),
  .adr_i      ( wb_adr_o   ),
  .dat_i      ( wb_dat_o   ),
  .tx_valid_i ( tx_valid_o ),
  .tx_ready_i ( tx_ready_i ),
  .tx_byte_i  ( tx_byte_o  )
);

// File: verilog/dbg_bus_pkg.sv
// Wishbone side types of the debug bridge for address, data and length
`include "uart_dbg_consts.svh"

package dbg_bus_pkg;

  // Byte address on the bus
  typedef logic [`DBG_ADDR_W-1:0] wb_adr_t;

  // Byte-wide bus data that also carries the UART byte
  typedef logic [7:0] wb_dat_t;

  // Remaining bytes of a transfer
  typedef logic [`DBG_LEN_W-1:0] dbg_len_t;

endpackage

// File: verilog/dbg_cmd_engine.sv
// Debug command parser and byte-wide Wishbone classic master
`include "uart_dbg_consts.svh"

module dbg_cmd_engine import dbg_proto_pkg::*, dbg_bus_pkg::*; (
  input  logic    clk,
  input  logic    reset_i,
  // Received bytes
  input  logic    rx_valid_i,
  input  wb_dat_t rx_byte_i,
  // Reply bytes
  input  logic    tx_ready_i,
  output logic    tx_valid_o,
  output wb_dat_t tx_byte_o,
  // Wishbone master
  output logic    wb_cyc_o,
  output logic    wb_stb_o,
  output logic    wb_we_o,
  output wb_adr_t wb_adr_o,
  output wb_dat_t wb_dat_o,
  input  wb_dat_t wb_dat_i,
  input  logic    wb_ack_i
);

  localparam int unsigned HDR_CNT_W = $clog2(`DBG_HDR_BYTES);
  localparam logic [HDR_CNT_W-1:0] HDR_LAST = HDR_CNT_W'(`DBG_HDR_BYTES - 1);

  dbg_state_e             state_q, state_d;
  dbg_hdr_u               hdr_q, hdr_next;
  logic [HDR_CNT_W-1:0]   hdr_cnt_q;
  logic                   in_hdr;
  logic                   hdr_last;
  logic                   is_write_q;
  logic                   cyc_q, cyc_d;
  logic                   tx_valid_d;
  logic                   tx_load;
  wb_dat_t                tx_byte_d;
  wb_adr_t                adr_q;
  dbg_len_t               len_q;
  wb_dat_t                wdat_q;
  logic                   bus_done;

  assign in_hdr   = (state_q == ST_HDR_ADDR) || (state_q == ST_HDR_LEN);
  assign hdr_last = in_hdr && rx_valid_i && (hdr_cnt_q == HDR_LAST);
  assign bus_done = cyc_q && wb_ack_i;

  // First byte ends up lowest for little-endian fields
  assign hdr_next.bytes = {rx_byte_i, hdr_q.bytes[`DBG_HDR_BYTES-1:1]};

  assign wb_cyc_o = cyc_q;
  assign wb_stb_o = cyc_q;
  assign wb_we_o  = (state_q == ST_BUS_WRITE);
  assign wb_adr_o = adr_q;
  assign wb_dat_o = wdat_q;

  ////////////////////
  // Command FSM
  ////////////////////

  always_comb begin
    state_d    = state_q;
    cyc_d      = cyc_q;
    tx_valid_d = tx_valid_o;
    tx_load    = 1'b0;
    tx_byte_d  = `DBG_BYTE_EOT;
    case (state_q)
      ST_IDLE: begin
        if (rx_valid_i) begin
          if (rx_byte_i == `DBG_BYTE_ACK) begin
            // Challenge reply goes out through the closing-byte state
            tx_valid_d = 1'b1;
            tx_load    = 1'b1;
            tx_byte_d  = `DBG_BYTE_ACK;
            state_d    = ST_SEND_EOT;
          end else if (rx_byte_i == DBG_OP_READ || rx_byte_i == DBG_OP_WRITE) begin
            state_d = ST_HDR_ADDR;
          end
        end
      end
      ST_HDR_ADDR: begin
        if (hdr_last) begin
          state_d = ST_HDR_LEN;
        end
      end
      ST_HDR_LEN: begin
        if (hdr_last) begin
          tx_valid_d = 1'b1;
          tx_load    = 1'b1;
          tx_byte_d  = `DBG_BYTE_ACK;
          state_d    = ST_SEND_ACK;
        end
      end
      ST_SEND_ACK, ST_SEND_DATA: begin
        if (tx_ready_i) begin
          if (len_q == '0) begin
            // Valid stays up and EOT follows straight away
            tx_load = 1'b1;
            state_d = ST_SEND_EOT;
          end else if (is_write_q) begin
            tx_valid_d = 1'b0;
            state_d    = ST_RECV_DATA;
          end else begin
            tx_valid_d = 1'b0;
            cyc_d      = 1'b1;
            state_d    = ST_BUS_READ;
          end
        end
      end
      ST_BUS_READ: begin
        if (wb_ack_i) begin
          cyc_d      = 1'b0;
          tx_valid_d = 1'b1;
          tx_load    = 1'b1;
          tx_byte_d  = wb_dat_i;
          state_d    = ST_SEND_DATA;
        end
      end
      ST_RECV_DATA: begin
        if (rx_valid_i) begin
          cyc_d   = 1'b1;
          state_d = ST_BUS_WRITE;
        end
      end
      ST_BUS_WRITE: begin
        if (wb_ack_i) begin
          cyc_d = 1'b0;
          if (len_q == dbg_len_t'(1)) begin
            tx_valid_d = 1'b1;
            tx_load    = 1'b1;
            state_d    = ST_SEND_EOT;
          end else begin
            state_d = ST_RECV_DATA;
          end
        end
      end
      ST_SEND_EOT: begin
        if (tx_ready_i) begin
          tx_valid_d = 1'b0;
          state_d    = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q    <= ST_IDLE;
      hdr_cnt_q  <= '0;
      cyc_q      <= 1'b0;
      tx_valid_o <= 1'b0;
    end else begin
      state_q    <= state_d;
      cyc_q      <= cyc_d;
      tx_valid_o <= tx_valid_d;
      if (!in_hdr) begin
        hdr_cnt_q <= '0;
      end else if (rx_valid_i) begin
        hdr_cnt_q <= hdr_last ? '0 : hdr_cnt_q + 1'b1;
      end
    end
  end

  ////////////////////
  // Datapath
  ////////////////////

  always_ff @(posedge clk) begin
    if (in_hdr && rx_valid_i) begin
      hdr_q <= hdr_next;
    end
    if (state_q == ST_IDLE && rx_valid_i) begin
      is_write_q <= (rx_byte_i == DBG_OP_WRITE);
    end
    // Upper header bits are dropped here
    if (hdr_last && state_q == ST_HDR_ADDR) begin
      adr_q <= hdr_next.value[`DBG_ADDR_W-1:0];
    end else if (bus_done) begin
      adr_q <= adr_q + 1'b1;
    end
    if (hdr_last && state_q == ST_HDR_LEN) begin
      len_q <= hdr_next.value[`DBG_LEN_W-1:0];
    end else if (bus_done) begin
      len_q <= len_q - 1'b1;
    end
    if (state_q == ST_RECV_DATA && rx_valid_i) begin
      wdat_q <= rx_byte_i;
    end
    if (tx_load) begin
      tx_byte_o <= tx_byte_d;
    end
  end

endmodule

// File: verilog/dbg_proto_pkg.sv
// Debug protocol types for opcodes, engine states and the header field
`include "uart_dbg_consts.svh"

package dbg_proto_pkg;

  // Command opcodes accepted in idle
  typedef enum logic [7:0] {
    DBG_OP_READ  = 8'h11,
    DBG_OP_WRITE = 8'h12
  } dbg_opcode_e;

  // Command engine states
  typedef enum logic [3:0] {
    ST_IDLE,
    ST_HDR_ADDR,
    ST_HDR_LEN,
    ST_SEND_ACK,
    ST_BUS_READ,
    ST_SEND_DATA,
    ST_RECV_DATA,
    ST_BUS_WRITE,
    ST_SEND_EOT
  } dbg_state_e;

  // Header field that is shifted in byte by byte and then taken as one
  // little-endian value
  typedef union packed {
    logic [`DBG_HDR_BYTES-1:0][7:0] bytes;
    logic [8*`DBG_HDR_BYTES-1:0]    value;
  } dbg_hdr_u;

endpackage

// File: verilog/uart_dbg_consts.svh
// UART debug bridge constants for bit timing, bus widths and protocol bytes
`ifndef UART_DBG_CONSTS_SVH
`define UART_DBG_CONSTS_SVH

// Clock cycles per serial bit
`define DBG_CLKS_PER_BIT 16

// Bus address and transfer length widths
`define DBG_ADDR_W 32
`define DBG_LEN_W 16

// Address and length fields on the wire are eight bytes each
`define DBG_HDR_BYTES 8

// Reply bytes
`define DBG_BYTE_ACK 8'h06
`define DBG_BYTE_EOT 8'h04

`endif

// File: verilog/uart_dbg_top.sv
// UART debug bridge top level joining receiver, command engine and transmitter
`include "uart_dbg_consts.svh"

module uart_dbg_top (
  input  logic                   clk,
  input  logic                   reset_i,
  // Serial line
  input  logic                   uart_rx_i,
  output logic                   uart_tx_o,
  // Wishbone master
  output logic                   wb_cyc_o,
  output logic                   wb_stb_o,
  output logic                   wb_we_o,
  output logic [`DBG_ADDR_W-1:0] wb_adr_o,
  output logic [7:0]             wb_dat_o,
  input  logic [7:0]             wb_dat_i,
  input  logic                   wb_ack_i
);

  logic       rx_valid;
  logic [7:0] rx_byte;
  logic       tx_valid;
  logic       tx_ready;
  logic [7:0] tx_byte;

  uart_rx u_rx (
    .clk        ( clk       ),
    .reset_i    ( reset_i   ),
    .rx_i       ( uart_rx_i ),
    .rx_valid_o ( rx_valid  ),
    .rx_byte_o  ( rx_byte   )
  );

  dbg_cmd_engine u_engine (
    .clk        ( clk      ),
    .reset_i    ( reset_i  ),
    .rx_valid_i ( rx_valid ),
    .rx_byte_i  ( rx_byte  ),
    .tx_ready_i ( tx_ready ),
    .tx_valid_o ( tx_valid ),
    .tx_byte_o  ( tx_byte  ),
    .wb_cyc_o   ( wb_cyc_o ),
    .wb_stb_o   ( wb_stb_o ),
    .wb_we_o    ( wb_we_o  ),
    .wb_adr_o   ( wb_adr_o ),
    .wb_dat_o   ( wb_dat_o ),
    .wb_dat_i   ( wb_dat_i ),
    .wb_ack_i   ( wb_ack_i )
  );

  uart_tx u_tx (
    .clk        ( clk       ),
    .reset_i    ( reset_i   ),
    .tx_valid_i ( tx_valid  ),
    .tx_byte_i  ( tx_byte   ),
    .tx_ready_o ( tx_ready  ),
    .tx_o       ( uart_tx_o )
  );

endmodule

// File: verilog/uart_rx.sv
// UART receiver that samples start, data and stop bits into bytes
`include "uart_dbg_consts.svh"

module uart_rx import dbg_bus_pkg::*; (
  input  logic    clk,
  input  logic    reset_i,
  input  logic    rx_i,
  output logic    rx_valid_o,
  output wb_dat_t rx_byte_o
);

  localparam int unsigned CNT_W = $clog2(`DBG_CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(`DBG_CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] CNT_HALF = CNT_W'(`DBG_CLKS_PER_BIT / 2 - 1);

  localparam logic [1:0] RX_IDLE  = 2'd0;
  localparam logic [1:0] RX_START = 2'd1;
  localparam logic [1:0] RX_DATA  = 2'd2;
  localparam logic [1:0] RX_STOP  = 2'd3;

  logic [1:0]       sync_q;
  logic [1:0]       state_q;
  logic [CNT_W-1:0] cnt_q;
  logic [2:0]       bit_q;
  wb_dat_t          shift_q;
  logic             rx_s;

  assign rx_s      = sync_q[1];
  assign rx_byte_o = shift_q;

  // Two-flop synchronizer that idles high like the line
  always_ff @(posedge clk) begin
    if (reset_i) begin
      sync_q <= 2'b11;
    end else begin
      sync_q <= {sync_q[0], rx_i};
    end
  end

  ////////////////////
  // Bit timing
  ////////////////////

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q    <= RX_IDLE;
      cnt_q      <= '0;
      bit_q      <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      rx_valid_o <= 1'b0;
      if (state_q == RX_IDLE) begin
        if (!rx_s) begin
          state_q <= RX_START;
          cnt_q   <= CNT_HALF;
        end
      end else if (cnt_q != '0) begin
        cnt_q <= cnt_q - 1'b1;
      end else begin
        cnt_q <= CNT_FULL;
        case (state_q)
          // Line back high at mid start bit means a glitch
          RX_START: begin
            state_q <= rx_s ? RX_IDLE : RX_DATA;
            bit_q   <= '0;
          end
          RX_DATA: begin
            bit_q <= bit_q + 1'b1;
            if (bit_q == 3'd7) begin
              state_q <= RX_STOP;
            end
          end
          default: begin
            // Framing error drops the byte silently
            rx_valid_o <= rx_s;
            state_q    <= RX_IDLE;
          end
        endcase
      end
    end
  end

  // LSB arrives first so bits enter at the top
  always_ff @(posedge clk) begin
    if (state_q == RX_DATA && cnt_q == '0) begin
      shift_q <= {rx_s, shift_q[7:1]};
    end
  end

endmodule

// File: verilog/uart_tx.sv
// UART transmitter that serializes one byte at a time
`include "uart_dbg_consts.svh"

module uart_tx import dbg_bus_pkg::*; (
  input  logic    clk,
  input  logic    reset_i,
  input  logic    tx_valid_i,
  input  wb_dat_t tx_byte_i,
  output logic    tx_ready_o,
  output logic    tx_o
);

  localparam int unsigned CNT_W = $clog2(`DBG_CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(`DBG_CLKS_PER_BIT - 1);

  // Start, eight data bits and stop
  localparam logic [3:0] FRAME_BITS = 4'd10;

  logic [9:0]       frame_q;
  logic [3:0]       bits_q;
  logic [CNT_W-1:0] cnt_q;
  logic             accept;

  assign tx_ready_o = (bits_q == '0);
  assign accept     = tx_valid_i && tx_ready_o;

  // Frame bit 0 drives the line and ones refill from the top
  assign tx_o = frame_q[0];

  ////////////////////
  // Shift out
  ////////////////////

  always_ff @(posedge clk) begin
    if (reset_i) begin
      frame_q <= '1;
      bits_q  <= '0;
      cnt_q   <= '0;
    end else if (accept) begin
      frame_q <= {1'b1, tx_byte_i, 1'b0};
      bits_q  <= FRAME_BITS;
      cnt_q   <= CNT_FULL;
    end else if (bits_q != '0) begin
      if (cnt_q == '0) begin
        frame_q <= {1'b1, frame_q[9:1]};
        bits_q  <= bits_q - 1'b1;
        cnt_q   <= CNT_FULL;
      end else begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

endmodule
